// ==== Bender.yml ====
package:
  name: spike_rate_monitor

sources:
  # packages first, then the design from leaf to top
  - src/spike_cfg_pkg.sv
  - src/spike_types_pkg.sv
  - src/spike_window_counter.sv
  - src/count_fifo.sv
  - src/burst_detector.sv
  - src/spike_rate_monitor.sv

  # testbench, top module spike_rate_monitor_tb
  - target: simulation
    files:
      - tb/spike_rate_monitor_asserts.sv
      - tb/spike_rate_monitor_tb.sv

// ==== spike_rate_monitor.f ====
src/spike_cfg_pkg.sv
src/spike_types_pkg.sv
src/spike_window_counter.sv
src/count_fifo.sv
src/burst_detector.sv
src/spike_rate_monitor.sv
tb/spike_rate_monitor_asserts.sv
tb/spike_rate_monitor_tb.sv

// ==== src/burst_detector.sv ====
`timescale 1ns/1ps

module burst_detector (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               hold,
    input  spike_types_pkg::window_rec_t       rd_rec,
    input  logic                               empty,
    output logic                               pop,
    output logic                               rate_valid,
    output logic                               burst,
    output logic                               burst_start,
    output logic [spike_cfg_pkg::COUNT_W-1:0]  rate_count,
    output logic                               rate_lost
);

    // high the cycle after a pop while rd_rec is fresh
    logic pop_q;

    logic is_burst;

    // at most one pop every second cycle and none while held
    assign pop = ~empty & ~hold & ~pop_q;

    assign is_burst = (rd_rec.count >=
                       spike_cfg_pkg::COUNT_W'(spike_cfg_pkg::BURST_THRESHOLD));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pop_q       <= 1'b0;
            rate_valid  <= 1'b0;
            burst_start <= 1'b0;
            burst       <= 1'b0;
            rate_count  <= '0;
            rate_lost   <= 1'b0;
        end else begin
            pop_q       <= pop;
            rate_valid  <= pop_q;
            burst_start <= 1'b0;
            if (pop_q) begin
                // report the record just loaded by the FIFO
                rate_count  <= rd_rec.count;
                rate_lost   <= rd_rec.lost;
                burst       <= is_burst;
                // burst still holds the flag of the last reported window
                burst_start <= is_burst & ~burst;
            end
        end
    end

endmodule

// ==== src/count_fifo.sv ====
`timescale 1ns/1ps

module count_fifo (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  spike_types_pkg::window_rec_t wr_rec,
    input  logic                         pop,
    output spike_types_pkg::window_rec_t rd_rec,
    output logic                         empty
);

    localparam int unsigned DEPTH = spike_cfg_pkg::FIFO_DEPTH;

    // circular record storage
    spike_types_pkg::window_rec_t mem [DEPTH];

    logic [spike_cfg_pkg::PTR_W-1:0] wr_ptr;
    logic [spike_cfg_pkg::PTR_W-1:0] rd_ptr;
    logic [spike_cfg_pkg::OCC_W-1:0] occ;

    // set by a dropped push, cleared by the next stored one
    logic pending_loss;

    logic full;
    logic accept;
    logic drop;
    logic take;

    assign full   = (occ == spike_cfg_pkg::OCC_W'(DEPTH));
    assign empty  = (occ == '0);
    assign accept = push & ~full;
    assign drop   = push & full;
    // pop is only legal when not empty, guard anyway
    assign take   = pop & ~empty;

    function automatic logic [spike_cfg_pkg::PTR_W-1:0] ptr_next(
        input logic [spike_cfg_pkg::PTR_W-1:0] ptr
    );
        // wrap at the last slot, depth need not be a power of two
        if (ptr == spike_cfg_pkg::PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            occ          <= '0;
            pending_loss <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr       <= ptr_next(wr_ptr);
                pending_loss <= 1'b0;
            end else if (drop) begin
                pending_loss <= 1'b1;
            end
            if (take) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // occupancy tracks accepted writes minus reads
            case ({accept, take})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr].count <= wr_rec.count;
            mem[wr_ptr].lost  <= wr_rec.lost | pending_loss;
        end
        if (take) begin
            rd_rec <= mem[rd_ptr];
        end
    end

endmodule

// ==== src/spike_cfg_pkg.sv ====
package spike_cfg_pkg;

    // clock cycles in one counting window
    localparam int unsigned WINDOW_CYCLES = 64;

    // width of a window count
    localparam int unsigned COUNT_W = 16;

    // record slots in the count FIFO
    localparam int unsigned FIFO_DEPTH = 4;

    // a window at or above this count is a burst
    localparam int unsigned BURST_THRESHOLD = 12;

    // window timer width
    localparam int unsigned TIMER_W = $clog2(WINDOW_CYCLES);

    // FIFO pointer width, at least one bit
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // occupancy runs 0..FIFO_DEPTH inclusive
    localparam int unsigned OCC_W = $clog2(FIFO_DEPTH + 1);

endpackage

// ==== src/spike_rate_monitor.sv ====
`timescale 1ns/1ps

module spike_rate_monitor (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              spike,
    input  logic                              hold,
    output logic                              rate_valid,
    output logic [spike_cfg_pkg::COUNT_W-1:0] rate_count,
    output logic                              rate_lost,
    output logic                              burst,
    output logic                              burst_start
);

    // counter to FIFO
    logic                         push;
    spike_types_pkg::window_rec_t wr_rec;

    // FIFO to detector
    logic                         pop;
    logic                         empty;
    spike_types_pkg::window_rec_t rd_rec;

    // producer, one record per window
    spike_window_counter u_counter (
        .clk    (clk),
        .reset  (reset),
        .spike  (spike),
        .push   (push),
        .wr_rec (wr_rec)
    );

    // buffer, drops on full and marks the loss
    count_fifo u_fifo (
        .clk    (clk),
        .reset  (reset),
        .push   (push),
        .wr_rec (wr_rec),
        .pop    (pop),
        .rd_rec (rd_rec),
        .empty  (empty)
    );

    // consumer, reports counts and burst status
    burst_detector u_detector (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .rd_rec      (rd_rec),
        .empty       (empty),
        .pop         (pop),
        .rate_valid  (rate_valid),
        .burst       (burst),
        .burst_start (burst_start),
        .rate_count  (rate_count),
        .rate_lost   (rate_lost)
    );

endmodule

// ==== src/spike_types_pkg.sv ====
package spike_types_pkg;

    // one record per finished window
    // count: rising spike edges seen in the window
    // lost: at least one earlier record was dropped since the last stored one
    typedef struct packed {
        logic [spike_cfg_pkg::COUNT_W-1:0] count;
        logic                              lost;
    } window_rec_t;

endpackage

// ==== src/spike_window_counter.sv ====
`timescale 1ns/1ps

module spike_window_counter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       spike,
    output logic                       push,
    output spike_types_pkg::window_rec_t wr_rec
);

    // two-stage synchroniser plus one stage for edge detection
    logic spike_s1;
    logic spike_s2;
    logic spike_prev;
    logic rise;

    // window timer and running edge count
    logic [spike_cfg_pkg::TIMER_W-1:0] timer;
    logic [spike_cfg_pkg::COUNT_W-1:0] edge_cnt;
    logic                              last_cycle;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spike_s1   <= 1'b0;
            spike_s2   <= 1'b0;
            spike_prev <= 1'b0;
        end else begin
            spike_s1   <= spike;
            spike_s2   <= spike_s1;
            spike_prev <= spike_s2;
        end
    end

    // high for one cycle per rising edge of the synchronised spike
    assign rise = spike_s2 & ~spike_prev;

    // final cycle of the current window
    assign last_cycle = (timer == spike_cfg_pkg::TIMER_W'(spike_cfg_pkg::WINDOW_CYCLES - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer    <= '0;
            edge_cnt <= '0;
            push     <= 1'b0;
        end else begin
            push <= last_cycle;
            if (last_cycle) begin
                // wrap; the edge of this cycle closes out with the old window
                timer    <= '0;
                edge_cnt <= '0;
            end else begin
                timer    <= timer + 1'b1;
                edge_cnt <= edge_cnt + spike_cfg_pkg::COUNT_W'(rise);
            end
        end
    end

    // closing count, including an edge found in the last cycle
    // only sampled together with push
    always_ff @(posedge clk) begin
        if (last_cycle) begin
            wr_rec.count <= edge_cnt + spike_cfg_pkg::COUNT_W'(rise);
            // loss marking belongs to the FIFO
            wr_rec.lost  <= 1'b0;
        end
    end

endmodule

// ==== tb/spike_rate_monitor_asserts.sv ====
`timescale 1ns/1ps

module spike_rate_monitor_asserts (
    input logic clk,
    input logic reset,
    input logic pop,
    input logic empty,
    input logic rate_valid,
    input logic burst,
    input logic burst_start
);

    // failures seen so far, read by the testbench
    int unsigned fail_count = 0;

    // no read from an empty FIFO
    pop_not_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else begin
            fail_count++;
            $error("pop issued while the FIFO is empty");
        end

    // reader spacing, at most one pop every second cycle
    pop_spacing: assert property (@(posedge clk) disable iff (reset) pop |=> !pop)
        else begin
            fail_count++;
            $error("pop high in two consecutive cycles");
        end

    // burst start only together with a reported burst window
    start_with_valid: assert property (@(posedge clk) disable iff (reset)
                                       burst_start |-> (rate_valid && burst))
        else begin
            fail_count++;
            $error("burst_start without rate_valid and burst");
        end

endmodule

// the detector sees both the FIFO read side and the output strobes
bind burst_detector spike_rate_monitor_asserts asserts0 (
    .clk         (clk),
    .reset       (reset),
    .pop         (pop),
    .empty       (empty),
    .rate_valid  (rate_valid),
    .burst       (burst),
    .burst_start (burst_start)
);

// ==== tb/spike_rate_monitor_tb.sv ====
`timescale 1ns/1ps

module spike_rate_monitor_tb;

    logic                              clk;
    logic                              reset;
    logic                              spike;
    logic                              hold;
    logic                              rate_valid;
    logic [spike_cfg_pkg::COUNT_W-1:0] rate_count;
    logic                              rate_lost;
    logic                              burst;
    logic                              burst_start;

    integer seed = 32'h7aa3;

    // reference model state, advanced on every rising edge
    logic                         m_d1;
    logic                         m_d2;
    logic                         m_d3;
    int                           m_pos;
    int                           m_cnt;
    logic                         m_push;
    spike_types_pkg::window_rec_t m_push_rec;
    spike_types_pkg::window_rec_t m_q[$];
    logic                         m_loss;
    logic                         m_pop_q;
    spike_types_pkg::window_rec_t m_rd;
    logic                         m_prev_burst;

    // predicted output registers
    logic                         exp_valid;
    logic                         exp_burst;
    logic                         exp_burst_start;
    spike_types_pkg::window_rec_t exp_rec;

    // result statistics from the output checker
    int n_results = 0;
    int n_lost = 0;
    int n_burst = 0;
    int n_quiet = 0;
    int n_starts = 0;
    int cyc = 0;
    int first_valid_cyc = 0;

    spike_rate_monitor dut0 (
        .clk         (clk),
        .reset       (reset),
        .spike       (spike),
        .hold        (hold),
        .rate_valid  (rate_valid),
        .rate_count  (rate_count),
        .rate_lost   (rate_lost),
        .burst       (burst),
        .burst_start (burst_start)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rec(input string name, input spike_types_pkg::window_rec_t exp,
                             input spike_types_pkg::window_rec_t act);
        if (exp !== act) begin
            fail_run($sformatf("ERR %0t %s expected count=%0d lost=%0b actual count=%0d lost=%0b",
                               $time, name, exp.count, exp.lost, act.count, act.lost));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("ERR %0t %s expected %0b actual %0b", $time, name, exp, act));
        end
    endtask

    // random spike toggling and hold level, probabilities in 1/256 steps
    task automatic drive_cycles(input int n, input int toggle_p, input int hold_p);
        int i;
        int r;
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            r = $random(seed) & 255;
            spike <= (r < toggle_p) ? ~spike : spike;
            r = $random(seed) & 255;
            hold <= (r < hold_p);
        end
    endtask

    // spike held at one level, hold low
    task automatic drive_level(input int n, input logic lvl);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            spike <= lvl;
            hold  <= 1'b0;
        end
    endtask

    // checker counters change on the falling edge, so poll on the rising one
    task automatic wait_results(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (n_results < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run("no rate_valid result arrived within the expected time");
            end
        end
    endtask

    // release hold and wait until the model sees no record in flight
    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        hold <= 1'b0;
        @(negedge clk);
        while (m_q.size() != 0 || m_pop_q || m_push) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run("FIFO did not drain after hold was released");
            end
        end
    endtask

    // reference model: sync delay, window count, FIFO queue, reader
    always @(posedge clk or posedge reset) begin : model_step
        logic                         rise;
        logic                         pop_now;
        logic                         was_full;
        logic                         hit;
        spike_types_pkg::window_rec_t rec;
        if (reset) begin
            m_d1 = 1'b0;
            m_d2 = 1'b0;
            m_d3 = 1'b0;
            m_pos = 0;
            m_cnt = 0;
            m_push = 1'b0;
            m_push_rec = '0;
            m_q.delete();
            m_loss = 1'b0;
            m_pop_q = 1'b0;
            m_rd = '0;
            m_prev_burst = 1'b0;
            exp_valid = 1'b0;
            exp_burst = 1'b0;
            exp_burst_start = 1'b0;
            exp_rec = '0;
        end else begin
            // edge seen two samples after the spike was taken
            rise = m_d2 & ~m_d3;
            pop_now = (m_q.size() != 0) && !hold && !m_pop_q;
            was_full = (m_q.size() == spike_cfg_pkg::FIFO_DEPTH);
            // output stage reports the record read one cycle earlier
            exp_valid = m_pop_q;
            exp_burst_start = 1'b0;
            if (m_pop_q) begin
                hit = (m_rd.count >= spike_cfg_pkg::BURST_THRESHOLD);
                exp_rec = m_rd;
                exp_burst = hit;
                exp_burst_start = hit && !m_prev_burst;
                m_prev_burst = hit;
            end
            if (pop_now) begin
                m_rd = m_q.pop_front();
            end
            m_pop_q = pop_now;
            // drop on full, mark the loss on the next stored record
            if (m_push) begin
                if (was_full) begin
                    m_loss = 1'b1;
                end else begin
                    rec = m_push_rec;
                    rec.lost = m_loss;
                    m_q.push_back(rec);
                    m_loss = 1'b0;
                end
            end
            m_push = 1'b0;
            if (m_pos == spike_cfg_pkg::WINDOW_CYCLES - 1) begin
                m_push_rec.count = m_cnt + rise;
                m_push_rec.lost = 1'b0;
                m_push = 1'b1;
                m_pos = 0;
                m_cnt = 0;
            end else begin
                m_pos++;
                m_cnt += rise;
            end
            m_d3 = m_d2;
            m_d2 = m_d1;
            m_d1 = spike;
        end
    end

    // every output compared each cycle, midway between rising edges
    always @(negedge clk) begin : output_check
        spike_types_pkg::window_rec_t act;
        act.count = rate_count;
        act.lost = rate_lost;
        if (!reset) begin
            cyc++;
            check_flag("rate_valid", exp_valid, rate_valid);
            check_flag("burst_start", exp_burst_start, burst_start);
            check_flag("burst", exp_burst, burst);
            check_rec("rate_count/rate_lost", exp_rec, act);
            if (dut0.u_detector.asserts0.fail_count != 0) begin
                fail_run("a bound assertion on the FIFO read side or strobes failed");
            end
            if (rate_valid) begin
                if (n_results == 0) begin
                    first_valid_cyc = cyc;
                end
                n_results++;
                n_lost += rate_lost;
                n_starts += burst_start;
                if (burst) begin
                    n_burst++;
                end else begin
                    n_quiet++;
                end
            end
        end
    end

    initial begin : main_flow
        int w;
        int p;
        spike = 1'b0;
        hold = 1'b0;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // all outputs idle right after reset
        check_flag("rate_valid", 1'b0, rate_valid);
        check_flag("burst", 1'b0, burst);
        check_flag("burst_start", 1'b0, burst_start);
        check_rec("rate_count/rate_lost", '0, {rate_count, rate_lost});

        // first window, nothing may come out before it closes
        drive_cycles(spike_cfg_pkg::WINDOW_CYCLES, 16, 0);
        wait_results(1, 2 * spike_cfg_pkg::WINDOW_CYCLES);
        if (first_valid_cyc < spike_cfg_pkg::WINDOW_CYCLES) begin
            fail_run("first result appeared before the first window closed");
        end

        // sparse spikes, hold low
        drive_cycles(8 * spike_cfg_pkg::WINDOW_CYCLES, 16, 0);
        wait_drain(spike_cfg_pkg::WINDOW_CYCLES);

        // long high level, then toggling every cycle
        drive_level(3 * spike_cfg_pkg::WINDOW_CYCLES, 1'b1);
        drive_level(spike_cfg_pkg::WINDOW_CYCLES / 2, 1'b0);
        drive_cycles(2 * spike_cfg_pkg::WINDOW_CYCLES, 256, 0);
        drive_level(2 * spike_cfg_pkg::WINDOW_CYCLES, 1'b0);
        wait_drain(spike_cfg_pkg::WINDOW_CYCLES);

        // per-window rate mix around the burst threshold, short hold pulses
        for (w = 0; w < 16; w++) begin
            case ($random(seed) & 3)
                0:       p = 6;
                1:       p = 60;
                2:       p = 96;
                default: p = 256;
            endcase
            drive_cycles(spike_cfg_pkg::WINDOW_CYCLES, p, 12);
        end
        wait_drain(spike_cfg_pkg::WINDOW_CYCLES);

        // back-pressure longer than the FIFO, drops expected
        drive_cycles((spike_cfg_pkg::FIFO_DEPTH + 3) * spike_cfg_pkg::WINDOW_CYCLES, 40, 256);
        drive_cycles(3 * spike_cfg_pkg::WINDOW_CYCLES, 40, 0);
        wait_drain(spike_cfg_pkg::WINDOW_CYCLES);

        if (n_lost != 0 && n_starts != 0 && n_burst != 0 && n_quiet != 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("stimulus never produced a lost record, a burst start or a quiet window");
        end
    end

endmodule
